// File: verilog/mcu_params.svh
//********************************************************************
// Address widths and PROM size shared by the MCU subsystem RTL
// PROM words are 16 bits wide, RAM words 8 bits
//********************************************************************

`ifndef MCU_PARAMS_SVH
`define MCU_PARAMS_SVH

// Private work RAM, 2 KB
`define MCU_RAM_AW     11

// Shared RAM seen by both the MCU and the main CPU, 512 bytes
`define MCU_SHARED_AW  9

// Program PROM, 1024 instruction words
`define MCU_PROM_AW    10

// NMI entry point inside the PROM
`define MCU_NMI_VEC    10'h200

`endif

// File: verilog/mcu_pkg.sv
//********************************************************************
// Bus, Wishbone and instruction types for the MCU subsystem
// Opcodes 8 to 15 are not defined and run as no-ops in the core
//********************************************************************

`default_nettype none

`include "mcu_params.svh"

package mcu_pkg;

    // Eight-instruction accumulator ISA
    typedef enum logic [3:0] {
        LDI  = 4'h0,  // acc = imm
        LD   = 4'h1,  // acc = mem[addr]
        ST   = 4'h2,  // mem[addr] = acc
        ADD  = 4'h3,  // acc += mem[addr]
        JMP  = 4'h4,
        JZ   = 4'h5,
        OUT6 = 4'h6,  // port 6 = imm
        HLT  = 4'h7
    } mcu_op_e;

    // Address form, jumps take the low PROM_AW bits
    typedef struct packed {
        mcu_op_e     op;
        logic [11:0] addr;
    } mcu_addr_form_t;

    typedef struct packed {
        mcu_op_e     op;
        logic [3:0]  rsvd;   // Ignored by the core
        logic [7:0]  imm;
    } mcu_imm_form_t;

    // One 16-bit PROM word, two decodes
    typedef union packed {
        mcu_addr_form_t a;
        mcu_imm_form_t  i;
    } mcu_instr_u;

    // Core data bus, bit 11 of addr selects shared RAM
    typedef struct packed {
        logic [11:0] addr;
        logic [7:0]  wdata;
        logic        we;
    } mcu_bus_t;

    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`MCU_SHARED_AW-1:0] adr;
        logic [7:0]                dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // PROM download port
    typedef struct packed {
        logic                    we;
        logic [`MCU_PROM_AW-1:0] addr;
        logic [15:0]             data;
    } prom_wr_t;

endpackage

`default_nettype wire

// File: verilog/sync_ram.sv
//********************************************************************
// Byte RAM, one port, read data registered one cycle
// Write-first, no reset on contents
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
    parameter int AW = 9
) (
    input  logic          mcu_haltn,
    input  logic [AW-1:0] addr,
    input  logic [7:0]    data,
    input  logic          we,
    output logic [7:0]    q
);

    logic [7:0] mem [0:(2**AW)-1];

    always_ff @(posedge mcu_haltn) begin
        if (we) begin
            mem[addr] <= data;
            q         <= data;     // New data on read port
        end else begin
            q         <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/shared_ram_arbiter.sv
//********************************************************************
// Shared RAM arbiter, MCU always wins over the Wishbone port
// A CPU cycle stalls while mcu_ban is high, ack ends it
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "mcu_params.svh"

module shared_ram_arbiter import mcu_pkg::*; (
    input  logic                      mcu_haltn,
    input  logic                      rst_n,
    input  mcu_bus_t                  core_bus,
    input  logic                      core_sel,
    input  wb_req_t                   wb_req,
    output wb_rsp_t                   wb_rsp,
    output logic                      mcu_ban,
    output logic [`MCU_SHARED_AW-1:0] ram_addr,
    output logic [7:0]                ram_data,
    output logic                      ram_we,
    input  logic [7:0]                ram_q
);

    logic core_shared;   // MCU access to shared region
    logic wb_go;         // CPU request accepted this cycle
    logic ack_q;

    assign core_shared = core_sel & core_bus.addr[11];
    assign mcu_ban     = core_shared;

    // No second accept while ack is out
    assign wb_go = wb_req.cyc & wb_req.stb & ~ack_q & ~core_shared;

    always_comb begin
        if (core_shared) begin
            ram_addr = core_bus.addr[`MCU_SHARED_AW-1:0];
            ram_data = core_bus.wdata;
            ram_we   = core_bus.we;
        end else begin
            ram_addr = wb_req.adr;       // CPU address idles on the RAM
            ram_data = wb_req.dat;
            ram_we   = wb_go & wb_req.we;
        end
    end

    // Ack the cycle after accept, lines up with registered read
    always_ff @(posedge mcu_haltn or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_go;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = ram_q;   // Valid in the ack cycle

endmodule

`default_nettype wire

// File: verilog/mcu_io_ports.sv
//********************************************************************
// Port 6 register, NMI latch and interrupt to the main CPU
// Bit 0 low clears the NMI, bit 1 low raises irq_main
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module mcu_io_ports (
    input  logic       mcu_haltn,
    input  logic       rst_n,
    input  logic       p6_wr,
    input  logic [7:0] p6_data,
    input  logic       nmi_set,
    output logic       nmi,
    output logic       irq_main
);

    logic [7:0] p6_q;
    logic       nmi_set_d;   // Previous nmi_set for edge detect
    logic       nmi_q;
    logic       irq_q;
    logic       nmi_rise;

    assign nmi_rise = nmi_set & ~nmi_set_d;

    always_ff @(posedge mcu_haltn or negedge rst_n) begin
        if (!rst_n) begin
            p6_q      <= 8'hff;    // All port bits inactive
            nmi_set_d <= 1'b0;
            nmi_q     <= 1'b0;
            irq_q     <= 1'b0;
        end else begin
            nmi_set_d <= nmi_set;
            if (p6_wr) begin
                p6_q <= p6_data;
            end
            // Clear has priority over a new edge
            if (!p6_q[0]) begin
                nmi_q <= 1'b0;
            end else if (nmi_rise) begin
                nmi_q <= 1'b1;
            end
            // Follow the write directly so irq moves right after OUT6
            irq_q <= p6_wr ? ~p6_data[1] : ~p6_q[1];
        end
    end

    assign nmi      = nmi_q;
    assign irq_main = irq_q;

endmodule

`default_nettype wire

// File: verilog/mcu_core.sv
//********************************************************************
// Minimal accumulator MCU, stands in for the 63701
// 2 cycles per instruction, 3 for LD, ST and ADD; run low freezes it
// HLT sticks until reset; PROM may be written while running
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "mcu_params.svh"

module mcu_core import mcu_pkg::*; (
    input  logic       mcu_haltn,
    input  logic       rst_n,
    input  logic       run,
    input  prom_wr_t   prom_wr,
    output mcu_bus_t   bus,
    output logic       bus_sel,
    input  logic [7:0] rdata,
    input  logic       nmi,
    output logic       p6_wr,
    output logic [7:0] p6_data
);

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_e;

    logic [15:0]             prom [0:(2**`MCU_PROM_AW)-1];
    state_e                  state;
    logic [`MCU_PROM_AW-1:0] pc;
    logic [7:0]              acc;
    logic                    nmi_svc;   // NMI handler running
    mcu_instr_u              ir;
    mcu_op_e                 op;

    assign op = ir.a.op;   // Opcode sits in the same place in both views

    // PROM download and instruction fetch
    always_ff @(posedge mcu_haltn) begin
        if (prom_wr.we) begin
            prom[prom_wr.addr] <= prom_wr.data;
        end
        if (run && state == S_FETCH) begin
            ir <= mcu_instr_u'(prom[pc]);
        end
    end

    // Bus and port strobes, only in EXEC
    always_comb begin
        bus.addr  = ir.a.addr;
        bus.wdata = acc;
        bus.we    = 1'b0;
        bus_sel   = 1'b0;
        p6_wr     = 1'b0;
        p6_data   = ir.i.imm;
        if (run && state == S_EXEC) begin
            case (op)
                LD, ADD: bus_sel = 1'b1;   // Read, data back in MEM
                ST: begin
                    bus_sel = 1'b1;
                    bus.we  = 1'b1;
                end
                OUT6:    p6_wr   = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge mcu_haltn or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_FETCH;
            pc      <= '0;
            acc     <= 8'h00;
            nmi_svc <= 1'b0;
        end else if (run) begin
            if (!nmi) begin
                nmi_svc <= 1'b0;   // Rearm once the latch is cleared
            end
            case (state)
                S_FETCH: begin
                    if (nmi && !nmi_svc) begin
                        pc      <= `MCU_NMI_VEC;   // Refetch from vector
                        nmi_svc <= 1'b1;
                    end else begin
                        pc    <= pc + 1'b1;
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    state <= S_FETCH;
                    case (op)
                        LDI: acc <= ir.i.imm;
                        JMP: pc  <= ir.a.addr[`MCU_PROM_AW-1:0];
                        JZ: begin
                            if (acc == 8'h00) begin
                                pc <= ir.a.addr[`MCU_PROM_AW-1:0];
                            end
                        end
                        LD, ADD, ST: state <= S_MEM;
                        HLT:         state <= S_HALT;
                        default: ;   // OUT6 and undefined codes
                    endcase
                end
                S_MEM: begin
                    state <= S_FETCH;
                    case (op)
                        LD:  acc <= rdata;
                        ADD: acc <= acc + rdata;   // Wraps mod 256
                        default: ;                 // ST already written
                    endcase
                end
                default: state <= S_HALT;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/mcu_subsystem.sv
//********************************************************************
// Sound/sprite MCU subsystem top
// Main CPU sees the shared RAM over Wishbone, mcu_ban marks stalls
// run low freezes the MCU, load the PROM while it is low
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "mcu_params.svh"

module mcu_subsystem import mcu_pkg::*; (
    input  logic     mcu_haltn,
    input  logic     rst_n,
    input  logic     run,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    output logic     mcu_ban,
    input  logic     nmi_set,
    output logic     irq_main,
    input  prom_wr_t prom_wr
);

    mcu_bus_t                  core_bus;
    logic                      core_sel;
    logic [7:0]                core_rdata;
    logic [7:0]                ram_q;       // Private RAM read
    logic [7:0]                shared_q;
    logic [`MCU_SHARED_AW-1:0] sh_addr;
    logic [7:0]                sh_data;
    logic                      sh_we;
    logic                      ram_we;
    logic                      rd_shared;   // Region of last core access
    logic                      nmi;
    logic                      p6_wr;
    logic [7:0]                p6_data;

    mcu_core u_core (
        .mcu_haltn (mcu_haltn),
        .rst_n     (rst_n),
        .run       (run),
        .prom_wr   (prom_wr),
        .bus       (core_bus),
        .bus_sel   (core_sel),
        .rdata     (core_rdata),
        .nmi       (nmi),
        .p6_wr     (p6_wr),
        .p6_data   (p6_data)
    );

    // Private RAM only takes writes aimed below the shared region
    assign ram_we = core_sel & ~core_bus.addr[11] & core_bus.we;

    sync_ram #(.AW(`MCU_RAM_AW)) u_ram (
        .mcu_haltn (mcu_haltn),
        .addr      (core_bus.addr[`MCU_RAM_AW-1:0]),
        .data      (core_bus.wdata),
        .we        (ram_we),
        .q         (ram_q)
    );

    shared_ram_arbiter u_arb (
        .mcu_haltn (mcu_haltn),
        .rst_n     (rst_n),
        .core_bus  (core_bus),
        .core_sel  (core_sel),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .mcu_ban   (mcu_ban),
        .ram_addr  (sh_addr),
        .ram_data  (sh_data),
        .ram_we    (sh_we),
        .ram_q     (shared_q)
    );

    sync_ram #(.AW(`MCU_SHARED_AW)) u_shared (
        .mcu_haltn (mcu_haltn),
        .addr      (sh_addr),
        .data      (sh_data),
        .we        (sh_we),
        .q         (shared_q)
    );

    // Read data lags the address by one cycle
    always_ff @(posedge mcu_haltn or negedge rst_n) begin
        if (!rst_n) begin
            rd_shared <= 1'b0;
        end else begin
            rd_shared <= core_bus.addr[11];
        end
    end

    assign core_rdata = rd_shared ? shared_q : ram_q;

    mcu_io_ports u_io (
        .mcu_haltn (mcu_haltn),
        .rst_n     (rst_n),
        .p6_wr     (p6_wr),
        .p6_data   (p6_data),
        .nmi_set   (nmi_set),
        .nmi       (nmi),
        .irq_main  (irq_main)
    );

endmodule

`default_nettype wire

// File: verif/mcu_bus_checker.sv
//********************************************************************
// Wishbone and shared RAM arbitration assertions, bound to the arbiter
// Needs a simulator run with assertions enabled
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module mcu_bus_checker import mcu_pkg::*; (
    input logic     mcu_haltn,
    input logic     rst_n,
    input wb_req_t  wb_req,
    input wb_rsp_t  wb_rsp,
    input logic     mcu_ban
);

    // One ack per strobe
    ack_one_cycle: assert property (@(posedge mcu_haltn) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("Wishbone ack held for more than one cycle");

    ack_with_strobe: assert property (@(posedge mcu_haltn) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("Wishbone ack without cyc and stb");

    // CPU cycle never accepted, so never written, while banned
    no_cpu_write_banned: assert property (@(posedge mcu_haltn) disable iff (!rst_n)
        mcu_ban |=> !wb_rsp.ack)
        else $error("CPU cycle accepted while mcu_ban high");

    quiet_after_reset: assert property (@(posedge mcu_haltn)
        $rose(rst_n) |-> (!wb_rsp.ack && !mcu_ban))
        else $error("ack or mcu_ban high right after reset");

endmodule

bind shared_ram_arbiter mcu_bus_checker u_bus_chk (
    .mcu_haltn (mcu_haltn),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .mcu_ban   (mcu_ban)
);

`default_nettype wire

// File: verif/mcu_subsystem_tb.sv
//********************************************************************
// Directed tests for the MCU subsystem, each restarts the core
// Fixed waits follow the core's 2 and 3 cycle instruction timing
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "mcu_params.svh"

module mcu_subsystem_tb import mcu_pkg::*; ();

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 2000;   // Cycle budget per test

    logic        mcu_haltn;
    logic        rst_n;
    logic        run;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        mcu_ban;
    logic        nmi_set;
    logic        irq_main;
    prom_wr_t    prom_wr;
    logic [31:0] rng_state;
    int          errors;
    int          tests_failed;

    mcu_subsystem uut (.*);

    initial begin
        mcu_haltn = 1'b0;
        forever #2 mcu_haltn = ~mcu_haltn;   // 4 ns period
    end

    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge mcu_haltn);
        $display("Watchdog expired after %0d cycles, a test hung", NUM_TESTS * TEST_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic mcu_instr_u addr_form(input mcu_op_e op, input logic [11:0] addr);
        mcu_instr_u w;
        w.a.op   = op;
        w.a.addr = addr;
        return w;
    endfunction

    function automatic mcu_instr_u imm_form(input mcu_op_e op, input logic [7:0] imm);
        mcu_instr_u w;
        w.i.op   = op;
        w.i.rsvd = 4'h0;
        w.i.imm  = imm;
        return w;
    endfunction

    // Core view of a shared RAM byte
    function automatic logic [11:0] shared_at(input logic [8:0] a);
        return 12'h800 | {3'b000, a};
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge mcu_haltn);
    endtask

    task automatic restart_core();
        @(posedge mcu_haltn);
        rst_n <= 1'b0;
        run   <= 1'b0;
        idle(8);
        rst_n <= 1'b1;
    endtask

    task automatic start_run();
        @(posedge mcu_haltn);
        run <= 1'b1;
    endtask

    task automatic prom_load(input logic [9:0] addr, input mcu_instr_u word);
        @(posedge mcu_haltn);
        prom_wr <= '{1'b1, addr, word};
        @(posedge mcu_haltn);
        prom_wr.we <= 1'b0;
    endtask

    // Ack sampled mid-cycle, request dropped on the next edge
    task automatic wb_access(input logic we, input logic [8:0] adr, input logic [7:0] dat,
                             output logic [7:0] q);
        @(posedge mcu_haltn);
        wb_req <= '{1'b1, 1'b1, we, adr, dat};
        @(negedge mcu_haltn);
        while (!wb_rsp.ack) @(negedge mcu_haltn);
        q = wb_rsp.dat;
        @(posedge mcu_haltn);
        wb_req <= '0;
    endtask

    task automatic wb_write(input logic [8:0] adr, input logic [7:0] dat);
        logic [7:0] unused_q;
        wb_access(1'b1, adr, dat, unused_q);
    endtask

    task automatic wb_read(input logic [8:0] adr, output logic [7:0] q);
        wb_access(1'b0, adr, 8'h00, q);
    endtask

    task automatic check_byte(input string tname, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %02h actual %02h", tname, expected, actual);
        end
    endtask

    task automatic check_bit(input string tname, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %0b actual %0b", tname, expected, actual);
        end
    endtask

    task automatic report(input string tname, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: passed", tname);
        end else begin
            tests_failed++;
            $display("%s: failed, %0d errors", tname, errors - errs_before);
        end
    endtask

    // Eight distinct addresses, one per 16-byte block from base
    task automatic write_read_back(input string tname, input logic [8:0] base);
        logic [8:0] adrs [8];
        logic [7:0] vals [8];
        logic [7:0] rd;
        for (int i = 0; i < 8; i++) begin
            adrs[i] = base | 9'(i * 16) | 9'(next_rand() % 16);
            vals[i] = 8'(next_rand());
            wb_write(adrs[i], vals[i]);
        end
        for (int i = 0; i < 8; i++) begin
            wb_read(adrs[i], rd);
            check_byte(tname, vals[i], rd);
        end
    endtask

    task automatic cpu_ram_access();
        int e0;
        e0 = errors;
        restart_core();
        write_read_back("cpu_ram_access", 9'h000);   // Core frozen
        report("cpu_ram_access", e0);
    endtask

    task automatic program_store();
        int         e0;
        logic [7:0] v;
        logic [7:0] rd;
        e0 = errors;
        v  = 8'(next_rand());
        restart_core();
        wb_write(9'h1a0, ~v);                        // Stale value first
        prom_load(10'd0, imm_form(LDI, v));
        prom_load(10'd1, addr_form(ST, shared_at(9'h1a0)));
        prom_load(10'd2, imm_form(HLT, 8'h00));
        start_run();
        idle(2 + 3 + 2 + 2);
        wb_read(9'h1a0, rd);
        check_byte("program_store", v, rd);
        report("program_store", e0);
    endtask

    task automatic private_shared_add();
        int         e0;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] sum;
        logic [7:0] rd;
        e0  = errors;
        x   = 8'(next_rand());
        y   = 8'(next_rand());
        sum = x + y;                                 // Wraps mod 256
        restart_core();
        wb_write(9'h180, x);
        wb_write(9'h181, y);
        wb_write(9'h182, ~sum);
        prom_load(10'd0, addr_form(LD, shared_at(9'h180)));
        prom_load(10'd1, addr_form(ST, 12'h010));    // Private scratch byte
        prom_load(10'd2, addr_form(LD, shared_at(9'h181)));
        prom_load(10'd3, addr_form(ADD, 12'h010));
        prom_load(10'd4, addr_form(ST, shared_at(9'h182)));
        prom_load(10'd5, imm_form(HLT, 8'h00));
        start_run();
        idle(5 * 3 + 2 + 2);
        wb_read(9'h182, rd);
        check_byte("private_shared_add", sum, rd);
        report("private_shared_add", e0);
    endtask

    task automatic nmi_handshake();
        int         e0;
        int         polls;
        logic [9:0] vec;
        logic [7:0] marker;
        logic [7:0] rd;
        e0     = errors;
        vec    = `MCU_NMI_VEC;
        marker = 8'(next_rand()) | 8'h01;            // Never zero
        restart_core();
        wb_write(9'h190, 8'h00);
        prom_load(10'd0, addr_form(JMP, 12'h000));   // Idle loop
        prom_load(vec, imm_form(LDI, marker));
        prom_load(vec + 10'd1, addr_form(ST, shared_at(9'h190)));
        prom_load(vec + 10'd2, imm_form(OUT6, 8'hfe));   // Clear NMI
        prom_load(vec + 10'd3, imm_form(OUT6, 8'hff));
        prom_load(vec + 10'd4, addr_form(JMP, {2'b00, vec + 10'd4}));
        start_run();
        idle(10);
        wb_read(9'h190, rd);
        check_byte("nmi_handshake", 8'h00, rd);      // Handler not run yet
        @(posedge mcu_haltn);
        nmi_set <= 1'b1;
        @(posedge mcu_haltn);
        nmi_set <= 1'b0;
        polls = 0;
        while (rd !== marker && polls < 64) begin
            wb_read(9'h190, rd);
            polls++;
        end
        check_byte("nmi_handshake", marker, rd);
        report("nmi_handshake", e0);
    endtask

    task automatic main_irq();
        int e0;
        e0 = errors;
        restart_core();
        wb_write(9'h191, 8'h00);                     // Hold the core in its loop
        prom_load(10'd0, imm_form(OUT6, 8'hfd));
        prom_load(10'd1, addr_form(LD, shared_at(9'h191)));
        prom_load(10'd2, addr_form(JZ, 12'h001));
        prom_load(10'd3, imm_form(OUT6, 8'hff));
        prom_load(10'd4, imm_form(HLT, 8'h00));
        @(negedge mcu_haltn);
        check_bit("main_irq", 1'b0, irq_main);
        start_run();
        idle(10);
        @(negedge mcu_haltn);
        check_bit("main_irq", 1'b1, irq_main);
        wb_write(9'h191, 8'h01);                     // Release the loop
        idle(3 + 2 + 2 + 3);
        @(negedge mcu_haltn);
        check_bit("main_irq", 1'b0, irq_main);
        report("main_irq", e0);
    endtask

    task automatic ram_contention();
        int         e0;
        int         waited;
        logic       ban_seen;
        logic [7:0] rd;
        e0 = errors;
        restart_core();
        prom_load(10'd0, imm_form(LDI, 8'h5a));
        prom_load(10'd1, addr_form(ST, shared_at(9'h1f0)));   // Core hammers 0x1f0
        prom_load(10'd2, addr_form(JMP, 12'h001));
        start_run();
        ban_seen = 1'b0;
        waited   = 0;
        while (!ban_seen && waited < 16) begin       // First ST takes the RAM
            @(negedge mcu_haltn);
            ban_seen = mcu_ban;
            waited++;
        end
        check_bit("ram_contention", 1'b1, ban_seen);
        write_read_back("ram_contention", 9'h100);
        wb_read(9'h1f0, rd);
        check_byte("ram_contention", 8'h5a, rd);
        report("ram_contention", e0);
    endtask

    initial begin
        rst_n        = 1'b0;
        run          = 1'b0;
        wb_req       = '0;
        nmi_set      = 1'b0;
        prom_wr      = '0;
        rng_state    = 32'hc740_a183;
        errors       = 0;
        tests_failed = 0;
        cpu_ram_access();
        program_store();
        private_shared_add();
        nmi_handshake();
        main_irq();
        ram_contention();
        $display("Tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/mcu_pkg.sv
verilog/sync_ram.sv
verilog/shared_ram_arbiter.sv
verilog/mcu_io_ports.sv
verilog/mcu_core.sv
verilog/mcu_subsystem.sv
verif/mcu_bus_checker.sv
verif/mcu_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MCU subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mcu_subsystem_tb -f sim.f -o mcu_sim

out="$(./obj_dir/mcu_sim 2>&1 || true)"
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1
